//--- source/mem_map_pkg.sv
package mem_map_pkg;

    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 32;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [15:0]          window_t;

    // confreg window tags, kseg1 alias and physical
    localparam window_t CONFREG_WINDOW_KSEG1 = 16'hbfaf;
    localparam window_t CONFREG_WINDOW_PHYS  = 16'h1faf;

    // translation drops the segment bits
    localparam int    PHYS_ADDR_BITS = 29;
    localparam addr_t PHYS_ADDR_MASK = addr_t'((64'd1 << PHYS_ADDR_BITS) - 64'd1);

    typedef enum logic {
        CLASS_CACHED   = 1'b0,
        CLASS_UNCACHED = 1'b1
    } mem_class_t;

    typedef struct packed {
        logic  req;
        addr_t addr;
    } cpu_rd_req_t;

    typedef struct packed {
        logic       req;
        addr_t      paddr;
        mem_class_t mem_class;
    } class_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        data_t rdata;
    } cpu_rd_rsp_t;

endpackage

//--- source/axi_rd_pkg.sv
package axi_rd_pkg;

    import mem_map_pkg::*;

    typedef logic [3:0] axi_id_t;
    typedef logic [3:0] ar_len_t;
    typedef logic [2:0] ar_size_t;
    typedef logic [1:0] ar_burst_t;
    typedef logic [3:0] ar_cache_t;
    typedef logic [1:0] axi_resp_t;

    // cacheable vs device, no bufferable split needed
    localparam ar_cache_t ARCACHE_CACHED = 4'hf;
    localparam ar_cache_t ARCACHE_DEVICE = 4'h0;

    // single beat of four bytes
    localparam ar_len_t   AR_LEN_SINGLE = 4'd0;
    localparam ar_size_t  AR_SIZE_WORD  = 3'b010;
    localparam ar_burst_t AR_BURST_INCR = 2'b01;

    typedef struct packed {
        axi_id_t   id;
        addr_t     addr;
        ar_len_t   len;
        ar_size_t  size;
        ar_burst_t burst;
        ar_cache_t cache;
    } ar_chan_t;

    typedef struct packed {
        axi_id_t   id;
        data_t     data;
        axi_resp_t resp;
        logic      last;
    } r_chan_t;

endpackage

//--- source/req_classifier.sv
module req_classifier
    import mem_map_pkg::*;
#(
    parameter int NUM_PORTS = 2
) (
    input  cpu_rd_req_t cpu_req   [NUM_PORTS],
    output class_req_t  class_req [NUM_PORTS]
);

    window_t win [NUM_PORTS];
    logic    in_confreg [NUM_PORTS];

    // upper halfword selects the window
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            win[i] = cpu_req[i].addr[ADDR_BITS-1 -: $bits(window_t)];
        end
    end

    // both aliases of the confreg block go uncached
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            in_confreg[i] = (win[i] == CONFREG_WINDOW_KSEG1) ||
                            (win[i] == CONFREG_WINDOW_PHYS);
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            class_req[i].req = cpu_req[i].req;
            // kseg0/kseg1 style fold into low memory
            class_req[i].paddr = cpu_req[i].addr & PHYS_ADDR_MASK;
            if (in_confreg[i]) begin
                class_req[i].mem_class = CLASS_UNCACHED;
            end else begin
                class_req[i].mem_class = CLASS_CACHED;
            end
        end
    end

endmodule

//--- source/port_tracker.sv
module port_tracker
    import mem_map_pkg::*, axi_rd_pkg::*;
#(
    parameter int NUM_PORTS   = 2,
    parameter int QUEUE_DEPTH = 4,
    parameter int PORT_ID     = 0
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  class_req_t  class_req,
    input  logic        grant,
    input  r_chan_t     r,
    input  logic        rvalid,
    output cpu_rd_rsp_t cpu_rsp,
    output logic        issue_valid,
    output ar_chan_t    issue_ar
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(QUEUE_DEPTH);
    // port index kept inside the id range the bridge hands out
    localparam axi_id_t MY_ID = axi_id_t'((PORT_ID < NUM_PORTS) ? PORT_ID : NUM_PORTS - 1);

    // class of every outstanding read, oldest at rd_ptr
    mem_class_t class_q [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             q_empty;
    logic             q_full;
    logic             class_ok;
    logic             addr_ok;

    logic     hold_valid;
    ar_chan_t hold_ar;

    logic  r_hit;
    logic  rsp_valid;
    data_t rsp_data;

    assign q_empty = (count == '0);
    assign q_full  = (count == FULL_COUNT);

    // a class switch waits until this port has drained
    assign class_ok = q_empty || (class_req.mem_class == class_q[rd_ptr]);
    assign addr_ok  = class_req.req && !hold_valid && !q_full && class_ok;

    assign r_hit = rvalid && (r.id == MY_ID);

    always_ff @(posedge aclk) begin
        if (addr_ok) begin
            class_q[wr_ptr] <= class_req.mem_class;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            hold_valid <= 1'b0;
            rsp_valid  <= 1'b0;
        end else begin
            if (addr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // entry retires with its data_ok
            if (rsp_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({addr_ok, rsp_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // grant only comes while the hold register is full
            if (addr_ok) begin
                hold_valid <= 1'b1;
            end else if (grant) begin
                hold_valid <= 1'b0;
            end
            rsp_valid <= r_hit;
        end
    end

    always_ff @(posedge aclk) begin
        if (addr_ok) begin
            hold_ar.id    <= MY_ID;
            hold_ar.addr  <= class_req.paddr;
            hold_ar.len   <= AR_LEN_SINGLE;
            hold_ar.size  <= AR_SIZE_WORD;
            hold_ar.burst <= AR_BURST_INCR;
            if (class_req.mem_class == CLASS_UNCACHED) begin
                hold_ar.cache <= ARCACHE_DEVICE;
            end else begin
                hold_ar.cache <= ARCACHE_CACHED;
            end
        end
        if (r_hit) begin
            rsp_data <= r.data;
        end
    end

    assign issue_valid = hold_valid;
    assign issue_ar    = hold_ar;

    always_comb begin
        cpu_rsp.addr_ok = addr_ok;
        cpu_rsp.data_ok = rsp_valid;
        cpu_rsp.rdata   = rsp_data;
    end

endmodule

//--- source/ar_arbiter.sv
module ar_arbiter
    import axi_rd_pkg::*;
#(
    parameter int NUM_PORTS = 2
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic [NUM_PORTS-1:0] issue_valid,
    input  ar_chan_t             issue_ar [NUM_PORTS],
    input  logic                 arready,
    output logic [NUM_PORTS-1:0] grant,
    output ar_chan_t             ar,
    output logic                 arvalid
);

    localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    typedef enum logic {
        AR_IDLE,
        AR_BUSY
    } ar_state_t;

    ar_state_t        state;
    logic [IDX_W-1:0] last_idx;
    logic [IDX_W-1:0] pick_idx;
    logic             pick_found;

    // search starts one past the last winner
    always_comb begin
        int cand;
        pick_found = 1'b0;
        pick_idx   = last_idx;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            cand = (int'(last_idx) + i) % NUM_PORTS;
            if (!pick_found && issue_valid[cand]) begin
                pick_found = 1'b1;
                pick_idx   = cand[IDX_W-1:0];
            end
        end
    end

    // one-cycle pulse, idle only lasts a cycle once something is valid
    always_comb begin
        grant = '0;
        if (state == AR_IDLE && pick_found) begin
            grant[pick_idx] = 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state    <= AR_IDLE;
            last_idx <= '0;
        end else begin
            case (state)
                AR_IDLE: begin
                    if (pick_found) begin
                        last_idx <= pick_idx;
                        state    <= AR_BUSY;
                    end
                end
                AR_BUSY: begin
                    if (arready) begin
                        state <= AR_IDLE;
                    end
                end
                default: state <= AR_IDLE;
            endcase
        end
    end

    // fields only load from idle, so they hold while waiting for arready
    always_ff @(posedge aclk) begin
        if (state == AR_IDLE && pick_found) begin
            ar <= issue_ar[pick_idx];
        end
    end

    assign arvalid = (state == AR_BUSY);

endmodule

//--- source/cpu_read_bridge.sv
module cpu_read_bridge
    import mem_map_pkg::*, axi_rd_pkg::*;
#(
    parameter int NUM_PORTS   = 2,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic        aclk,
    input  logic        aresetn,

    // port 0 fetch, port 1 load
    input  cpu_rd_req_t cpu_req [NUM_PORTS],
    output cpu_rd_rsp_t cpu_rsp [NUM_PORTS],

    output ar_chan_t    ar,
    output logic        arvalid,
    input  logic        arready,

    input  r_chan_t     r,
    input  logic        rvalid,
    output logic        rready
);

    class_req_t           class_req [NUM_PORTS];
    logic [NUM_PORTS-1:0] issue_valid;
    ar_chan_t             issue_ar [NUM_PORTS];
    logic [NUM_PORTS-1:0] grant;

    req_classifier #(
        .NUM_PORTS (NUM_PORTS)
    ) u_classifier (
        .cpu_req   (cpu_req),
        .class_req (class_req)
    );

    genvar p;
    generate
        for (p = 0; p < NUM_PORTS; p++) begin : g_port
            port_tracker #(
                .NUM_PORTS   (NUM_PORTS),
                .QUEUE_DEPTH (QUEUE_DEPTH),
                .PORT_ID     (p)
            ) u_tracker (
                .aclk        (aclk),
                .aresetn     (aresetn),
                .class_req   (class_req[p]),
                .grant       (grant[p]),
                .r           (r),
                .rvalid      (rvalid),
                .cpu_rsp     (cpu_rsp[p]),
                .issue_valid (issue_valid[p]),
                .issue_ar    (issue_ar[p])
            );
        end
    endgenerate

    ar_arbiter #(
        .NUM_PORTS (NUM_PORTS)
    ) u_arbiter (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .issue_valid (issue_valid),
        .issue_ar    (issue_ar),
        .arready     (arready),
        .grant       (grant),
        .ar          (ar),
        .arvalid     (arvalid)
    );

    // every issued read has a slot waiting for its beat
    assign rready = 1'b1;

endmodule

//--- tb/cpu_read_bridge_assert.sv
module cpu_read_bridge_assert
    import axi_rd_pkg::*;
#(
    parameter int NUM_PORTS = 2
) (
    input logic                 aclk,
    input logic                 aresetn,
    input logic [NUM_PORTS-1:0] grant,
    input ar_chan_t             ar,
    input logic                 arvalid,
    input logic                 arready
);

    // a stalled AR keeps every field until it is taken
    a_ar_stable: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (arvalid && !arready) |=> (arvalid && $stable(ar))
    ) else $error("AR changed while arready was low");

    // each grant opens exactly one AR, and each AR comes from one grant
    a_grant_opens_ar: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (grant != '0) |=> $rose(arvalid)
    ) else $error("grant did not start an AR");

    a_ar_has_grant: assert property (
        @(posedge aclk) disable iff (!aresetn)
        $rose(arvalid) |-> $onehot($past(grant))
    ) else $error("AR started without a single grant");

endmodule

bind ar_arbiter cpu_read_bridge_assert #(
    .NUM_PORTS (NUM_PORTS)
) u_ar_assert (
    .aclk    (aclk),
    .aresetn (aresetn),
    .grant   (grant),
    .ar      (ar),
    .arvalid (arvalid),
    .arready (arready)
);

//--- tb/cpu_read_bridge_tb.sv
module cpu_read_bridge_tb
    import mem_map_pkg::*, axi_rd_pkg::*;
();

    localparam int NUM_PORTS   = 2;
    localparam int QUEUE_DEPTH = 4;
    localparam int NUM_REQS    = 40;
    localparam int MAX_DELAY   = 7;
    localparam int MAX_STALL   = 7;
    localparam int TOTAL_READS = NUM_REQS * NUM_PORTS;
    localparam int CYCLE_LIMIT = NUM_REQS * (MAX_DELAY + MAX_STALL + 8) * NUM_PORTS;
    // top three bits cleared
    localparam logic [31:0] PHYS_MASK = 32'h1fff_ffff;

    logic        aclk;
    logic        aresetn;
    cpu_rd_req_t cpu_req [NUM_PORTS];
    cpu_rd_rsp_t cpu_rsp [NUM_PORTS];
    ar_chan_t    ar;
    logic        arvalid;
    logic        arready;
    r_chan_t     r;
    logic        rvalid;
    logic        rready;

    logic [15:0] lfsr;
    logic        timed_out;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          rcv_total = 0;
    int          acc_cnt [NUM_PORTS] = '{default: 0};
    int          ar_cnt [NUM_PORTS] = '{default: 0};
    int          rcv_cnt [NUM_PORTS] = '{default: 0};
    int          wait_hs [NUM_PORTS] = '{default: 0};
    logic [3:0]  last_cache [NUM_PORTS] = '{default: 4'hx};
    logic [31:0] data_q [NUM_PORTS][$];
    logic [31:0] ar_q [NUM_PORTS][$];
    logic [31:0] slave_q [NUM_PORTS][$];
    // ARs seen on the bus for the slave model to replay
    int          ar_log_id [TOTAL_READS];
    logic [31:0] ar_log_addr [TOTAL_READS];
    int          ar_log_n = 0;
    logic        prev_stall = 1'b0;
    ar_chan_t    prev_ar;

    cpu_read_bridge #(
        .NUM_PORTS   (NUM_PORTS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) DUT (
        .aclk    (aclk),
        .aresetn (aresetn),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    // fixed mix of the physical address
    function automatic logic [31:0] mem_word(input logic [31:0] pa);
        return {pa[15:0], pa[31:16]} ^ (pa << 5) ^ 32'h3c5a_96e1;
    endfunction

    function automatic logic [3:0] expected_cache(input logic [31:0] va);
        if (va[31:16] == 16'hbfaf || va[31:16] == 16'h1faf) begin
            return ARCACHE_DEVICE;
        end
        return ARCACHE_CACHED;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // about one in four lands in a confreg window
    function automatic logic [31:0] pick_addr();
        logic [31:0] hi;
        logic [31:0] low;
        if (rand_bits(2) == 0) begin
            hi = rand_bits(1);
            low = rand_bits(14);
            return {(hi[0] ? 16'hbfaf : 16'h1faf), low[13:0], 2'b00};
        end
        hi = rand_bits(1);
        low = rand_bits(27);
        return {2'b10, hi[0], low[26:0], 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    initial begin
        aclk = 1'b0;
        forever begin
            #10 aclk = ~aclk;
        end
    end

    // compare process sampling on the rising edge
    always @(posedge aclk) begin
        int          aid;
        logic [31:0] va;
        logic [3:0]  exp_cache;
        if (aresetn) begin
            cycles++;
            if (rvalid) begin
                check_value("rready", 64'(1), 64'(rready));
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (cpu_req[p].req && cpu_rsp[p].addr_ok) begin
                    data_q[p].push_back(cpu_req[p].addr);
                    ar_q[p].push_back(cpu_req[p].addr);
                    acc_cnt[p]++;
                end
                if (cpu_rsp[p].data_ok) begin
                    if (data_q[p].size() == 0) begin
                        errors++;
                        $display("port %0d returned data with no read outstanding", p);
                    end else begin
                        va = data_q[p].pop_front();
                        check_value("data_return", 64'(mem_word(va & PHYS_MASK)),
                                    64'(cpu_rsp[p].rdata));
                    end
                    rcv_cnt[p]++;
                    rcv_total++;
                end
            end
            if (prev_stall) begin
                check_value("ar_held_valid", 64'(1), 64'(arvalid));
                check_value("ar_held_fields", 64'(prev_ar), 64'(ar));
            end
            prev_stall = arvalid && !arready;
            prev_ar = ar;
            if (arvalid && arready) begin
                aid = int'(ar.id);
                if (aid >= NUM_PORTS || ar_q[aid].size() == 0) begin
                    errors++;
                    $display("AR with id %0d matches no accepted request", aid);
                end else begin
                    va = ar_q[aid].pop_front();
                    exp_cache = expected_cache(va);
                    check_value("ar_addr", 64'(va & PHYS_MASK), 64'(ar.addr));
                    check_value("ar_cache", 64'(exp_cache), 64'(ar.cache));
                    check_value("ar_len", 64'(0), 64'(ar.len));
                    check_value("ar_size", 64'(AR_SIZE_WORD), 64'(ar.size));
                    check_value("ar_burst", 64'(AR_BURST_INCR), 64'(ar.burst));
                    // switching class needs every earlier read of the port returned
                    if (ar_cnt[aid] > 0 && last_cache[aid] != exp_cache) begin
                        check_value("class_switch_drained", 64'(ar_cnt[aid]),
                                    64'(rcv_cnt[aid]));
                    end
                    last_cache[aid] = exp_cache;
                    ar_cnt[aid]++;
                    ar_log_id[ar_log_n] = aid;
                    ar_log_addr[ar_log_n] = ar.addr;
                    ar_log_n++;
                    for (int q = 0; q < NUM_PORTS; q++) begin
                        if (q == aid) begin
                            wait_hs[q] = 0;
                        end else if (acc_cnt[q] > ar_cnt[q]) begin
                            wait_hs[q]++;
                            check_value("ar_fairness", 64'(1), 64'(wait_hs[q] <= NUM_PORTS));
                        end
                    end
                end
            end
        end
    end

    // requests, arready stalls and the AXI slave on the falling edge
    initial begin
        int   gap;
        int   stall;
        int   start;
        int   sid;
        int   taken;
        logic found;
        int   sent [NUM_PORTS];
        int   idle [NUM_PORTS];
        lfsr = 16'd54727;
        arready = 1'b0;
        rvalid = 1'b0;
        r = '0;
        gap = 0;
        stall = 0;
        taken = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            cpu_req[p] = '0;
            sent[p] = 0;
            idle[p] = 0;
        end
        wait (aresetn);
        forever begin
            @(negedge aclk);
            while (taken < ar_log_n) begin
                slave_q[ar_log_id[taken]].push_back(ar_log_addr[taken]);
                taken++;
            end
            rvalid = 1'b0;
            if (gap > 0) begin
                gap--;
            end else begin
                // random starting id lets the slave interleave ports
                start = int'(rand_bits(2)) % NUM_PORTS;
                found = 1'b0;
                for (int i = 0; i < NUM_PORTS; i++) begin
                    sid = (start + i) % NUM_PORTS;
                    if (!found && slave_q[sid].size() > 0) begin
                        found = 1'b1;
                        rvalid = 1'b1;
                        r.id = axi_id_t'(sid);
                        r.data = mem_word(slave_q[sid].pop_front());
                        r.resp = 2'b00;
                        r.last = 1'b1;
                    end
                end
                if (found) begin
                    gap = int'(rand_bits(3));
                end
            end
            if (stall > 0) begin
                arready = 1'b0;
                stall--;
            end else begin
                arready = 1'b1;
                if (rand_bits(2) == 0) begin
                    stall = int'(rand_bits(3));
                end
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (cpu_req[p].req && acc_cnt[p] == sent[p]) begin
                    cpu_req[p].req = 1'b0;
                end
                if (!cpu_req[p].req && sent[p] < NUM_REQS) begin
                    if (idle[p] > 0) begin
                        idle[p]--;
                    end else begin
                        cpu_req[p].addr = pick_addr();
                        cpu_req[p].req = 1'b1;
                        sent[p]++;
                        idle[p] = int'(rand_bits(2));
                    end
                end
            end
        end
    end

    initial begin
        aresetn = 1'b0;
        repeat (5) @(negedge aclk);
        aresetn = 1'b1;
        while (rcv_total < TOTAL_READS && cycles < CYCLE_LIMIT) begin
            @(negedge aclk);
        end
        timed_out = (rcv_total < TOTAL_READS);
        if (timed_out) begin
            $display("timeout after %0d cycles, %0d of %0d reads returned",
                     cycles, rcv_total, TOTAL_READS);
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, int'(timed_out));
        if (errors == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- cpu_read_bridge.f
source/mem_map_pkg.sv
source/axi_rd_pkg.sv
source/req_classifier.sv
source/port_tracker.sv
source/ar_arbiter.sv
source/cpu_read_bridge.sv
tb/cpu_read_bridge_assert.sv
tb/cpu_read_bridge_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Verilator build and run of the CPU read bridge testbench

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=cpu_read_bridge_sim
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module cpu_read_bridge_tb \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
    -f cpu_read_bridge.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0
